// File: picoPortIf.f
+incdir+include
verilog/picoPortPkg.sv
verilog/portRegs.sv
verilog/boardAccess.sv
verilog/linkEvents.sv
verilog/readPort.sv
verilog/picoPortIf.sv
tb/picoPortIf_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module picoPortIf_tb -f picoPortIf.f -o simv

out=$(./obj_dir/simv 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'All tests passed!'; then
  echo "simulation PASSED"
else
  echo "simulation FAILED"
  exit 1
fi

// File: tb/picoPortIf_tb.sv
`timescale 1ns/1ps
`include "picoPort_defines.svh"

module picoPortIf_tb;

  // one table row, held on the bus for one cycle
  typedef struct packed {
    logic [7:0] portId;
    logic [7:0] outData;
    logic       we;       // write strobe
    logic [1:0] usVal;    // us board RAM output during the row
    logic       chk;      // compare inPort one cycle later
    logic [7:0] exp;
  } stepT;

  localparam logic WR = 1'b1, RD = 1'b0;   // strobe column
  localparam logic CK = 1'b1, NC = 1'b0;   // check column

  logic                   clk = 1'b0;
  logic                   arstN;
  picoPortPkg::portBusT   bus;
  logic [7:0]             inPort, rxData, txData;
  logic [4:0]             btns;
  logic [15:0]            sw, leds;
  logic                   connEst, rxReady, txReady, txValid;
  logic                   intRequest, interruptAck, interrupt;
  picoPortPkg::boardPortT usBoard, themBoard;
  picoPortPkg::cellT      usReadValue, themReadValue;

  stepT        tbl[$];
  logic        tableReady = 1'b0;
  logic [31:0] lcgState = 32'h90b013ad;
  int          usPulses = 0;
  int          themPulses = 0;

  picoPortIf u_picoPortIf (.*);

  always #5 clk = ~clk;  // 10 ns period

  ////////////////////
  // helpers
  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic addStep(input logic [7:0] id, input logic [7:0] data, input logic we,
                         input logic [1:0] uv, input logic chk, input logic [7:0] exp);
    tbl.push_back({id, data, we, uv, chk, exp});
  endtask

  task automatic buildTable();
    addStep(`PA_LEDS,        8'h5A, WR, 2'd0, NC, 8'h00);
    addStep(`PA_LEDS1508,    8'hC3, WR, 2'd0, NC, 8'h00);
    addStep(`PA_OOB,         8'h12, WR, 2'd0, NC, 8'h00);
    addStep(`PA_LEDS,        8'h00, RD, 2'd0, CK, 8'h5A);
    addStep(`PA_LEDS1508,    8'h00, RD, 2'd0, CK, 8'hC3);
    addStep(`PA_OOB,         8'h00, RD, 2'd0, CK, 8'h12);
    addStep(`PA_LEDS,        8'h77, RD, 2'd0, NC, 8'h00);  // no strobe, no write
    addStep(`PA_OOB,         8'h99, RD, 2'd0, NC, 8'h00);
    addStep(`PA_OOB,         8'h00, RD, 2'd0, CK, 8'h12);
    // us board, value before address
    addStep(`PA_RAM_W_VAL,   8'h02, WR, 2'd0, NC, 8'h00);
    addStep(`PA_WRITE_ADDR,  8'h21, WR, 2'd0, NC, 8'h00);
    addStep(`PA_READ_ADDR,   8'h33, WR, 2'd0, NC, 8'h00);
    addStep(`PA_READ_ADDR,   8'h00, RD, 2'd0, CK, 8'h33);
    addStep(`PA_WRITE_ADDR,  8'h00, RD, 2'd0, CK, 8'h21);
    addStep(`PA_RAM_W_VAL,   8'h00, RD, 2'd0, CK, 8'h02);
    // them board
    addStep(`PA_RAM_SELECT,  8'h01, WR, 2'd0, NC, 8'h00);
    addStep(`PA_RAM_SELECT,  8'h00, RD, 2'd0, CK, 8'h01);
    addStep(`PA_READ_ADDR,   8'h00, RD, 2'd0, CK, 8'h00);  // them board still clear
    addStep(`PA_RAM_W_VAL,   8'h03, WR, 2'd0, NC, 8'h00);
    addStep(`PA_WRITE_ADDR,  8'h44, WR, 2'd0, NC, 8'h00);
    addStep(`PA_READ_ADDR,   8'h55, WR, 2'd0, NC, 8'h00);
    addStep(`PA_READ_ADDR,   8'h00, RD, 2'd0, CK, 8'h55);
    addStep(`PA_WRITE_ADDR,  8'h00, RD, 2'd0, CK, 8'h44);
    addStep(`PA_RAM_W_VAL,   8'h00, RD, 2'd0, CK, 8'h03);
    addStep(`PA_DATA_RAM,    8'h00, RD, 2'd0, CK, 8'h03);  // themReadValue
    addStep(`PA_RAM_SELECT,  8'h00, WR, 2'd0, NC, 8'h00);
    addStep(`PA_READ_ADDR,   8'h00, RD, 2'd0, CK, 8'h33);  // us untouched
    addStep(`PA_WRITE_ADDR,  8'h00, RD, 2'd0, CK, 8'h21);
    addStep(`PA_RAM_W_VAL,   8'h00, RD, 2'd0, CK, 8'h02);
    addStep(`PA_DATA_RAM,    8'h00, RD, 2'd1, CK, 8'h01);  // also feeds the sum
    // placement check
    addStep(`PA_VALID_FLAG,  8'h00, RD, 2'd0, CK, `INVALID_FLAG);
    addStep(8'h05,           8'h00, RD, 2'd3, CK, 8'h00);  // clear edge drops this 3
    addStep(`PA_VALID_FLAG,  8'h00, RD, 2'd0, CK, `VALID_FLAG);
    addStep(8'h05,           8'h00, RD, 2'd0, NC, 8'h00);
    addStep(8'h05,           8'h00, RD, 2'd2, NC, 8'h00);
    addStep(`PA_VALID_FLAG,  8'h00, RD, 2'd0, CK, `INVALID_FLAG);
    addStep(`PA_OOB,         `OUT_OF_BOUNDS, WR, 2'd0, NC, 8'h00);
    addStep(`PA_VALID_FLAG,  8'h00, RD, 2'd0, CK, `INVALID_FLAG);
    addStep(`PA_OOB,         8'h00, WR, 2'd0, NC, 8'h00);
    addStep(`PA_VALID_FLAG,  8'h00, RD, 2'd0, CK, `VALID_FLAG);
    // plain inputs
    addStep(`PA_PBTNS,       8'h00, RD, 2'd0, CK, 8'h15);
    addStep(`PA_PBTNS_ALT,   8'h00, RD, 2'd0, CK, 8'h15);
    addStep(`PA_SLSWTCH,     8'h00, RD, 2'd0, CK, 8'h3C);
    addStep(`PA_SLSWTCH1508, 8'h00, RD, 2'd0, CK, 8'hA5);
    addStep(`PA_DATA_RX,     8'h00, RD, 2'd0, CK, 8'h6E);
    addStep(`PA_STATUS,      8'h00, RD, 2'd0, CK, 8'h80);  // connEst only
    addStep(8'h1C,           8'h00, RD, 2'd0, CK, 8'h00);  // unmapped
  endtask

  // transfer of one byte, a second write arrives while busy
  task automatic sendByte(input logic [7:0] data);
    logic prevVal;
    logic prevRdy;
    int   n;
    @(posedge clk);
    #1;
    bus = {`PA_DATA_TX, data, 1'b1};
    @(posedge clk);
    #1;
    bus.outData = ~data;  // must be dropped
    @(negedge clk);
    check(32'(txValid), 32'd1, "txValid");
    prevVal = txValid;
    prevRdy = txReady;
    @(posedge clk);
    #1;
    bus = {`PA_STATUS, 8'h00, 1'b0};
    for (n = 1; prevVal || n < 4; n++) begin
      @(negedge clk);
      check(32'(txValid), 32'(prevVal && !prevRdy), "txValid");
      check(32'(txData), 32'(data), "txData");
      if (n >= 2) check(32'(inPort), prevVal ? 32'h60 : 32'h40, "inPort status");  // lags a cycle
      prevVal = txValid;
      prevRdy = txReady;
    end
  endtask

  task automatic stepIrq(input logic req, input logic ack, input logic exp);
    @(posedge clk);
    #1;
    intRequest   = req;
    interruptAck = ack;
    @(posedge clk);  // latch samples here
    @(negedge clk);
    check(32'(interrupt), 32'(exp), "interrupt");
  endtask

  ////////////////////
  // link responder with random stalls
  initial begin : responder
    int stall;
    txReady = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (txValid && !txReady) begin
        lcgState = lcgNext(lcgState);
        stall = int'(lcgState[18:16]) % 5;  // 0 to 4 cycles
        repeat (stall) begin
          @(posedge clk);
          #1;
        end
        txReady = 1'b1;
        @(posedge clk);
        #1;
        txReady = 1'b0;
      end
    end
  end

  always @(negedge clk) begin  // writeEn pulses per board
    if (usBoard.writeEn) begin
      usPulses++;
      check(32'(usBoard.writeAddr), 32'h21, "usBoard.writeAddr");
      check(32'(usBoard.writeValue), 32'h2, "usBoard.writeValue");
    end
    if (themBoard.writeEn) begin
      themPulses++;
      check(32'(themBoard.writeAddr), 32'h44, "themBoard.writeAddr");
      check(32'(themBoard.writeValue), 32'h3, "themBoard.writeValue");
    end
  end

  initial begin : watchdog
    wait (tableReady);
    #((tbl.size() + 200) * 10);
    $display("watchdog expired before the tests finished");
    $display("Test failures found");
    $fatal(1, "timeout");
  end

  ////////////////////
  // main sequence
  initial begin : main
    stepT s;
    arstN         = 1'b0;
    bus           = '0;
    btns          = 5'h15;
    sw            = 16'hA53C;
    connEst       = 1'b1;
    rxReady       = 1'b0;
    rxData        = 8'h6E;
    intRequest    = 1'b0;
    interruptAck  = 1'b0;
    usReadValue   = 2'd0;
    themReadValue = 2'd3;
    buildTable();
    tableReady = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    arstN = 1'b1;
    for (int i = 0; i <= tbl.size(); i++) begin
      @(posedge clk);
      #1;
      if (i > 0 && tbl[i-1].chk) begin
        check(32'(inPort), 32'(tbl[i-1].exp), $sformatf("inPort row %0d", i - 1));
      end
      s = (i < tbl.size()) ? tbl[i] : '0;
      bus         = {s.portId, s.outData, s.we};
      usReadValue = s.usVal;
    end
    check(32'(leds), 32'hC35A, "leds");
    check(usPulses, 32'd1, "usBoard.writeEn cycles");
    check(themPulses, 32'd1, "themBoard.writeEn cycles");
    check(32'(themBoard.readAddr), 32'h55, "themBoard.readAddr");
    connEst = 1'b0;  // status reads 0x40 or 0x60 during the link steps
    rxReady = 1'b1;
    sendByte(8'hA7);
    sendByte(8'h3C);
    sendByte(8'hE1);
    stepIrq(1'b1, 1'b0, 1'b1);  // request sets
    stepIrq(1'b0, 1'b0, 1'b1);  // holds
    stepIrq(1'b1, 1'b1, 1'b0);  // ack wins
    stepIrq(1'b0, 1'b0, 1'b0);
    stepIrq(1'b1, 1'b0, 1'b1);
    stepIrq(1'b0, 1'b1, 1'b0);
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: verilog/picoPortIf.sv
`timescale 1ns/1ps
`include "picoPort_defines.svh"

module picoPortIf (
  input  logic                   clk,
  input  logic                   arstN,
  input  picoPortPkg::portBusT   bus,
  output logic [`PP_DATA_W-1:0]  inPort,
  input  logic [`PP_BTN_W-1:0]   btns,
  input  logic [`PP_SW_W-1:0]    sw,
  input  logic                   connEst,
  input  logic                   rxReady,
  input  logic [`PP_DATA_W-1:0]  rxData,
  input  logic                   txReady,
  output logic [`PP_DATA_W-1:0]  txData,
  output logic                   txValid,
  input  logic                   intRequest,
  input  logic                   interruptAck,
  output logic                   interrupt,
  output logic [`PP_LED_W-1:0]   leds,
  output picoPortPkg::boardPortT usBoard,
  output picoPortPkg::boardPortT themBoard,
  input  picoPortPkg::cellT      usReadValue,
  input  picoPortPkg::cellT      themReadValue
);

  picoPortPkg::panelCfgT cfg;  // config registers, shared

  portRegs u_portRegs (
    .clk(clk), .arstN(arstN), .bus(bus), .txBusy(txValid), .cfg(cfg)
  );

  boardAccess u_boardAccess (
    .clk(clk), .arstN(arstN), .bus(bus), .selectThem(cfg.selectThem),
    .usBoard(usBoard), .themBoard(themBoard)
  );

  linkEvents u_linkEvents (
    .clk(clk), .arstN(arstN), .bus(bus), .txReady(txReady), .txValid(txValid),
    .intRequest(intRequest), .interruptAck(interruptAck), .interrupt(interrupt)
  );

  readPort u_readPort (
    .clk(clk), .arstN(arstN), .portId(bus.portId), .cfg(cfg),
    .usBoard(usBoard), .themBoard(themBoard),
    .usReadValue(usReadValue), .themReadValue(themReadValue),
    .btns(btns), .sw(sw), .connEst(connEst), .rxReady(rxReady),
    .rxData(rxData), .txValid(txValid), .inPort(inPort)
  );

  assign txData = cfg.txData;  // link byte
  assign leds   = cfg.leds;

endmodule

// File: verilog/readPort.sv
`timescale 1ns/1ps
`include "picoPort_defines.svh"

module readPort (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`PP_DATA_W-1:0]  portId,
  input  picoPortPkg::panelCfgT  cfg,
  input  picoPortPkg::boardPortT usBoard,
  input  picoPortPkg::boardPortT themBoard,
  input  picoPortPkg::cellT      usReadValue,
  input  picoPortPkg::cellT      themReadValue,
  input  logic [`PP_BTN_W-1:0]   btns,
  input  logic [`PP_SW_W-1:0]    sw,
  input  logic                   connEst,
  input  logic                   rxReady,
  input  logic [`PP_DATA_W-1:0]  rxData,
  input  logic                   txValid,
  output logic [`PP_DATA_W-1:0]  inPort
);

  picoPortPkg::boardPortT selBoard;  // board named by select
  picoPortPkg::cellT      selValue;
  logic [`PP_DATA_W-1:0]  acc;       // running sum of us cells
  logic [`PP_DATA_W:0]    accSum;    // one spare bit for overflow
  logic                   clrPend;   // flag read seen, clear next
  logic [`PP_DATA_W-1:0]  validByte;

  assign selBoard = cfg.selectThem ? themBoard : usBoard;
  assign selValue = cfg.selectThem ? themReadValue : usReadValue;

  ////////////////////
  // placement check
  assign accSum    = {1'b0, acc} + {{(`PP_DATA_W + 1 - `PP_CELL_W){1'b0}}, usReadValue};
  assign validByte = ((cfg.oob != `OUT_OF_BOUNDS) && (acc == '0)) ?
                     `VALID_FLAG : `INVALID_FLAG;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      acc     <= '0;
      clrPend <= 1'b0;
    end else begin
      clrPend <= (portId == `PA_VALID_FLAG);
      if (clrPend) acc <= '0;                           // one edge after the read
      else if (accSum[`PP_DATA_W]) acc <= '1;           // saturate at 255
      else acc <= accSum[`PP_DATA_W-1:0];
    end
  end

  ////////////////////
  // registered read mux
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      inPort <= '0;
    end else begin
      case (portId)
        `PA_PBTNS, `PA_PBTNS_ALT: inPort <= {{(`PP_DATA_W - `PP_BTN_W){1'b0}}, btns};
        `PA_SLSWTCH:     inPort <= sw[7:0];
        `PA_SLSWTCH1508: inPort <= sw[15:8];
        `PA_LEDS:        inPort <= cfg.leds[7:0];
        `PA_LEDS1508:    inPort <= cfg.leds[15:8];
        `PA_OOB:         inPort <= cfg.oob;
        `PA_STATUS:      inPort <= {connEst, rxReady, txValid, 5'b00000};  // bits 7..5
        `PA_READ_ADDR:   inPort <= selBoard.readAddr;
        `PA_WRITE_ADDR:  inPort <= selBoard.writeAddr;
        `PA_VALID_FLAG:  inPort <= validByte;
        `PA_RAM_SELECT:  inPort <= {{(`PP_DATA_W - 1){1'b0}}, cfg.selectThem};
        `PA_RAM_W_VAL:   inPort <= {{(`PP_DATA_W - `PP_CELL_W){1'b0}}, selBoard.writeValue};
        `PA_DATA_RX:     inPort <= rxData;
        `PA_DATA_TX:     inPort <= cfg.txData;  // last byte loaded
        `PA_DATA_RAM:    inPort <= {{(`PP_DATA_W - `PP_CELL_W){1'b0}}, selValue};
        default:         inPort <= '0;          // unmapped
      endcase
    end
  end

endmodule

// File: verilog/linkEvents.sv
`timescale 1ns/1ps
`include "picoPort_defines.svh"

module linkEvents (
  input  logic                 clk,
  input  logic                 arstN,
  input  picoPortPkg::portBusT bus,
  input  logic                 txReady,       // link takes the byte
  output logic                 txValid,
  input  logic                 intRequest,
  input  logic                 interruptAck,  // from the processor
  output logic                 interrupt
);

  logic txWrite;

  assign txWrite = bus.writeStrobe && (bus.portId == `PA_DATA_TX);

  ////////////////////
  // transmit handshake
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      txValid <= 1'b0;
    end else if (txValid) begin
      if (txReady) txValid <= 1'b0;  // accepted on this edge
    end else if (txWrite) begin
      txValid <= 1'b1;  // txData loads on the same edge
    end
  end

  ////////////////////
  // closed loop interrupt, ack has priority
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      interrupt <= 1'b0;
    end else if (interruptAck) begin
      interrupt <= 1'b0;
    end else if (intRequest) begin
      interrupt <= 1'b1;
    end
  end

endmodule

// File: verilog/boardAccess.sv
`timescale 1ns/1ps
`include "picoPort_defines.svh"

module boardAccess (
  input  logic                   clk,
  input  logic                   arstN,
  input  picoPortPkg::portBusT   bus,
  input  logic                   selectThem,  // steers writes to one board
  output picoPortPkg::boardPortT usBoard,
  output picoPortPkg::boardPortT themBoard
);

  // index 0 is the us board, index 1 the them board
  picoPortPkg::boardPortT brd [0:1];

  logic wrReadAddr;
  logic wrWriteAddr;
  logic wrValue;

  // strobed write qualifiers
  assign wrReadAddr  = bus.writeStrobe && (bus.portId == `PA_READ_ADDR);
  assign wrWriteAddr = bus.writeStrobe && (bus.portId == `PA_WRITE_ADDR);
  assign wrValue     = bus.writeStrobe && (bus.portId == `PA_RAM_W_VAL);

  ////////////////////
  // per board registers
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      brd[0] <= '0;
      brd[1] <= '0;
    end else begin
      // enable is a pulse, dropped unless re-armed below
      brd[0].writeEn <= 1'b0;
      brd[1].writeEn <= 1'b0;

      if (wrReadAddr) begin
        brd[selectThem].readAddr <= bus.outData;
      end

      // value goes in first, address second
      if (wrValue) begin
        brd[selectThem].writeValue <= bus.outData[`PP_CELL_W-1:0];
      end

      if (wrWriteAddr) begin
        brd[selectThem].writeAddr <= bus.outData;
        brd[selectThem].writeEn   <= 1'b1;  // RAM writes on the next edge
      end
    end
  end

  assign usBoard   = brd[0];
  assign themBoard = brd[1];

endmodule

// File: verilog/portRegs.sv
`timescale 1ns/1ps
`include "picoPort_defines.svh"

module portRegs (
  input  logic                  clk,
  input  logic                  arstN,
  input  picoPortPkg::portBusT  bus,
  input  logic                  txBusy,   // link still owns txData
  output picoPortPkg::panelCfgT cfg
);

  logic [`PP_DATA_W-1:0] ledsLo;  // leds 7:0
  logic [`PP_DATA_W-1:0] ledsHi;  // leds 15:8
  logic                  selectThem;
  logic [`PP_DATA_W-1:0] oob;
  logic [`PP_DATA_W-1:0] txData;

  ////////////////////
  // strobed write decode
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ledsLo     <= '0;
      ledsHi     <= '0;
      selectThem <= 1'b0;  // us board after reset
      oob        <= '0;
      txData     <= '0;
    end else if (bus.writeStrobe) begin
      case (bus.portId)
        `PA_LEDS: begin
          ledsLo <= bus.outData;
        end
        `PA_LEDS1508: begin
          ledsHi <= bus.outData;
        end
        `PA_RAM_SELECT: begin
          selectThem <= bus.outData[0];  // only bit 0 is kept
        end
        `PA_OOB: begin
          oob <= bus.outData;
        end
        `PA_DATA_TX: begin
          // held stable for the whole handshake
          if (!txBusy) begin
            txData <= bus.outData;
          end
        end
        default: begin
          // inputs and board ports are handled elsewhere
        end
      endcase
    end
  end

  ////////////////////
  // pack for the other blocks
  always_comb begin
    cfg            = '0;
    cfg.leds       = {ledsHi, ledsLo};
    cfg.selectThem = selectThem;
    cfg.oob        = oob;
    cfg.txData     = txData;
  end

endmodule

// File: verilog/picoPortPkg.sv
`include "picoPort_defines.svh"

package picoPortPkg;

  // board cell code: 0 empty, 1 ship, 2 hit, 3 miss
  typedef logic [`PP_CELL_W-1:0] cellT;

  // processor output side, sampled by every block
  typedef struct packed {
    logic [`PP_DATA_W-1:0] portId;   // port address
    logic [`PP_DATA_W-1:0] outData;  // write data
    logic                  writeStrobe;
  } portBusT;

  // configuration registers as seen by the other blocks
  typedef struct packed {
    logic [`PP_LED_W-1:0]  leds;
    logic                  selectThem;  // 0 = us board, 1 = them board
    logic [`PP_DATA_W-1:0] oob;         // OUT_OF_BOUNDS marks a bad position
    logic [`PP_DATA_W-1:0] txData;      // byte for the link
  } panelCfgT;

  // one board RAM access port
  typedef struct packed {
    logic [`PP_DATA_W-1:0] readAddr;
    logic [`PP_DATA_W-1:0] writeAddr;
    logic                  writeEn;     // single cycle pulse
    cellT                  writeValue;
  } boardPortT;

endpackage

// File: include/picoPort_defines.svh
`ifndef PICOPORT_DEFINES_SVH
`define PICOPORT_DEFINES_SVH

// bus and field widths
`define PP_DATA_W 8   // port id and data byte
`define PP_CELL_W 2   // board cell code
`define PP_LED_W 16
`define PP_BTN_W 5
`define PP_SW_W 16

////////////////////
// port map, low bank
`define PA_PBTNS      8'h00  // (in) buttons
`define PA_SLSWTCH    8'h01  // (in) switches 7:0
`define PA_LEDS       8'h02  // (out) leds 7:0
`define PA_OOB        8'h08  // (out) out-of-bounds byte
`define PA_STATUS     8'h09  // (in) link status bits
`define PA_READ_ADDR  8'h0A  // (out) board read address
`define PA_WRITE_ADDR 8'h0B  // (out) board write address, fires writeEn
`define PA_VALID_FLAG 8'h0C  // (in) placement check result

////////////////////
// port map, high bank
`define PA_PBTNS_ALT   8'h10  // (in) buttons, alias
`define PA_SLSWTCH1508 8'h11  // (in) switches 15:8
`define PA_LEDS1508    8'h12  // (out) leds 15:8
`define PA_RAM_SELECT  8'h13  // (out) bit 0 picks the them board
`define PA_RAM_W_VAL   8'h18  // (out) cell value to write
`define PA_DATA_RX     8'h19  // (in) byte from the other board
`define PA_DATA_TX     8'h1E  // (out) byte to the other board
`define PA_DATA_RAM    8'h1F  // (in) cell read back from selected board

// flag values
`define OUT_OF_BOUNDS 8'hFF
`define VALID_FLAG    8'h01
`define INVALID_FLAG  8'h00

`endif
